// File: Makefile
# Verilator build and run of the SECDED memory testbench

VERILATOR ?= verilator
TOP       ?= ecc_mem_tb
FILELIST  ?= ecc_mem_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: ecc_mem_top.f
logic/secded_pkg.sv
logic/mem_req_pkg.sv
logic/secded_55_codec.sv
logic/ecc_word_ram.sv
logic/ecc_req_ctrl.sv
logic/ecc_err_log.sv
logic/ecc_mem_top.sv
test/ecc_mem_tb.sv

// File: logic/ecc_err_log.sv
module ecc_err_log
    import secded_pkg::*;
#(
    parameter int ADDR_W = 6,
    parameter int CNT_W  = 16
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              resp_fire,
    input  err_status_e       resp_status,
    input  logic [ADDR_W-1:0] err_addr,
    output logic [CNT_W-1:0]  sbit_count,
    output logic [CNT_W-1:0]  dbit_count,
    output logic [ADDR_W-1:0] last_err_addr
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sbit_count    <= '0;
            dbit_count    <= '0;
            last_err_addr <= '0;
        end else if (resp_fire) begin
            case (resp_status)
                ERR_CORRECTED: begin
                    if (sbit_count != '1) begin
                        sbit_count <= sbit_count + 1'b1;
                    end
                    last_err_addr <= err_addr;
                end
                ERR_UNCORRECTABLE: begin
                    if (dbit_count != '1) begin
                        dbit_count <= dbit_count + 1'b1; // stops at all ones
                    end
                    last_err_addr <= err_addr;
                end
                default: ;
            endcase
        end
    end

endmodule

// File: logic/ecc_mem_top.sv
module ecc_mem_top
    import secded_pkg::*;
    import mem_req_pkg::*;
#(
    parameter int ADDR_W = 6,
    parameter int CNT_W  = 16
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                bypass,
    input  logic                req_valid,
    output logic                req_ready,
    input  op_e                 req_op,
    input  logic [ADDR_W-1:0]   req_addr,
    input  logic [DATA_W-1:0]   req_wdata,
    input  logic [PARITY_W-1:0] req_wparity,
    output logic                resp_valid,
    input  logic                resp_ready,
    output logic [DATA_W-1:0]   resp_data,
    output err_status_e         resp_status,
    output logic [CNT_W-1:0]    sbit_count,
    output logic [CNT_W-1:0]    dbit_count,
    output logic [ADDR_W-1:0]   last_err_addr
);

    logic [DATA_W-1:0]   codec_data;
    logic [PARITY_W-1:0] codec_parity;
    logic [DATA_W-1:0]   corr_data;
    logic [PARITY_W-1:0] gen_parity;
    logic                sbit_err;
    logic                dbit_err;
    logic                ram_we;
    logic [ADDR_W-1:0]   ram_waddr;
    logic [CODE_W-1:0]   ram_wdata;
    logic                ram_re;
    logic [ADDR_W-1:0]   ram_raddr;
    logic [CODE_W-1:0]   ram_rdata;
    logic                resp_fire;
    logic [ADDR_W-1:0]   err_addr;

    secded_55_codec u_codec (
        .data_in    (codec_data),
        .parity_in  (codec_parity),
        .bypass     (bypass),
        .data_out   (corr_data),
        .parity_out (gen_parity),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    ecc_word_ram #(.ADDR_W(ADDR_W)) u_ram (
        .clk   (clk),
        .we    (ram_we),
        .waddr (ram_waddr),
        .wdata (ram_wdata),
        .re    (ram_re),
        .raddr (ram_raddr),
        .rdata (ram_rdata)
    );

    ecc_req_ctrl #(.ADDR_W(ADDR_W)) u_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .bypass       (bypass),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_op       (req_op),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .req_wparity  (req_wparity),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp_data    (resp_data),
        .resp_status  (resp_status),
        .codec_data   (codec_data),
        .codec_parity (codec_parity),
        .corr_data    (corr_data),
        .gen_parity   (gen_parity),
        .sbit_err     (sbit_err),
        .dbit_err     (dbit_err),
        .ram_we       (ram_we),
        .ram_waddr    (ram_waddr),
        .ram_wdata    (ram_wdata),
        .ram_re       (ram_re),
        .ram_raddr    (ram_raddr),
        .ram_rdata    (ram_rdata),
        .resp_fire    (resp_fire),
        .err_addr     (err_addr)
    );

    ecc_err_log #(.ADDR_W(ADDR_W), .CNT_W(CNT_W)) u_log (
        .clk           (clk),
        .arst_n        (arst_n),
        .resp_fire     (resp_fire),
        .resp_status   (resp_status),
        .err_addr      (err_addr),
        .sbit_count    (sbit_count),
        .dbit_count    (dbit_count),
        .last_err_addr (last_err_addr)
    );

endmodule

// File: logic/ecc_req_ctrl.sv
module ecc_req_ctrl
    import secded_pkg::*;
    import mem_req_pkg::*;
#(
    parameter int ADDR_W = 6
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                bypass,
    input  logic                req_valid,
    output logic                req_ready,
    input  op_e                 req_op,
    input  logic [ADDR_W-1:0]   req_addr,
    input  logic [DATA_W-1:0]   req_wdata,
    input  logic [PARITY_W-1:0] req_wparity,
    output logic                resp_valid,
    input  logic                resp_ready,
    output logic [DATA_W-1:0]   resp_data,
    output err_status_e         resp_status,
    output logic [DATA_W-1:0]   codec_data,
    output logic [PARITY_W-1:0] codec_parity,
    input  logic [DATA_W-1:0]   corr_data,
    input  logic [PARITY_W-1:0] gen_parity,
    input  logic                sbit_err,
    input  logic                dbit_err,
    output logic                ram_we,
    output logic [ADDR_W-1:0]   ram_waddr,
    output logic [CODE_W-1:0]   ram_wdata,
    output logic                ram_re,
    output logic [ADDR_W-1:0]   ram_raddr,
    input  logic [CODE_W-1:0]   ram_rdata,
    output logic                resp_fire,
    output logic [ADDR_W-1:0]   err_addr
);

    ctrl_state_e       state;
    ctrl_state_e       state_nxt;
    logic [ADDR_W-1:0] rd_addr;
    logic [DATA_W-1:0] corr_q;
    logic              req_fire;
    logic              do_scrub;

    assign req_ready  = (state == ST_IDLE);
    assign req_fire   = req_valid && req_ready;
    assign resp_valid = (state == ST_RESP);
    assign resp_fire  = resp_valid && resp_ready;
    assign do_scrub   = sbit_err && !bypass;

    // codec input follows the state
    always_comb begin
        case (state)
            ST_RESP: begin
                codec_data   = ram_rdata[DATA_W-1:0];
                codec_parity = ram_rdata[CODE_W-1:DATA_W];
            end
            ST_SCRUB: begin
                codec_data   = corr_q;
                codec_parity = '0; // only gen_parity is used here
            end
            default: begin
                codec_data   = req_wdata;
                codec_parity = req_wparity;
            end
        endcase
    end

    assign resp_data = corr_data;

    always_comb begin
        if (dbit_err) begin
            resp_status = ERR_UNCORRECTABLE;
        end else if (sbit_err) begin
            resp_status = ERR_CORRECTED;
        end else begin
            resp_status = ERR_NONE;
        end
    end

    assign ram_re    = req_fire && (req_op == OP_READ);
    assign ram_raddr = req_addr;

    always_comb begin
        ram_we    = 1'b0;
        ram_waddr = req_addr;
        ram_wdata = {gen_parity, req_wdata};
        if (state == ST_SCRUB) begin
            ram_we    = 1'b1;
            ram_waddr = rd_addr;
            ram_wdata = {gen_parity, corr_q}; // fresh check bits
        end else if (req_fire && req_op == OP_WRITE) begin
            ram_we = 1'b1;
        end else if (req_fire && req_op == OP_WRITE_RAW) begin
            ram_we    = 1'b1;
            ram_wdata = {req_wparity, req_wdata};
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:  if (ram_re) state_nxt = ST_RESP;
            ST_RESP:  if (resp_fire) state_nxt = do_scrub ? ST_SCRUB : ST_IDLE;
            ST_SCRUB: state_nxt = ST_IDLE;
            default:  state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (ram_re) begin
            rd_addr <= req_addr;
        end
        if (resp_fire) begin
            corr_q <= corr_data; // write-back source for the scrub
        end
    end

    assign err_addr = rd_addr;

endmodule

// File: logic/ecc_word_ram.sv
module ecc_word_ram
    import secded_pkg::*;
#(
    parameter int ADDR_W = 6
) (
    input  logic              clk,
    input  logic              we,
    input  logic [ADDR_W-1:0] waddr,
    input  logic [CODE_W-1:0] wdata,
    input  logic              re,
    input  logic [ADDR_W-1:0] raddr,
    output logic [CODE_W-1:0] rdata
);

    logic [CODE_W-1:0] mem [2**ADDR_W];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        if (re) begin
            rdata <= mem[raddr]; // holds between reads, the response relies on it
        end
    end

endmodule

// File: logic/mem_req_pkg.sv
package mem_req_pkg;

    typedef enum logic [1:0] {
        OP_READ      = 2'd0,
        OP_WRITE     = 2'd1, // check bits come from the encoder
        OP_WRITE_RAW = 2'd2  // check bits come from req_wparity
    } op_e;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_RESP  = 2'd1,
        ST_SCRUB = 2'd2
    } ctrl_state_e;

endpackage

// File: logic/secded_55_codec.sv
module secded_55_codec
    import secded_pkg::*;
(
    input  logic [DATA_W-1:0]   data_in,
    input  logic [PARITY_W-1:0] parity_in,
    input  logic                bypass,
    output logic [DATA_W-1:0]   data_out,
    output logic [PARITY_W-1:0] parity_out,
    output logic                sbit_err,
    output logic                dbit_err
);

    // column of the check matrix for every data bit
    // low six bits hold the hamming position, the top bit keeps the column odd weight
    function automatic logic [DATA_W-1:0][PARITY_W-1:0] build_cols();
        logic [DATA_W-1:0][PARITY_W-1:0] cols;
        int idx;
        cols = '0;
        idx  = 0;
        // positions 3..61 minus the powers of two give exactly 55 columns
        for (int pos = 3; pos < 62; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                cols[idx] = {~^pos[5:0], pos[5:0]};
                idx++;
            end
        end
        return cols;
    endfunction

    localparam logic [DATA_W-1:0][PARITY_W-1:0] H_COLS = build_cols();

    function automatic logic [PARITY_W-1:0] encode(input logic [DATA_W-1:0] d);
        logic [PARITY_W-1:0] p;
        p = '0;
        for (int k = 0; k < PARITY_W; k++) begin
            for (int i = 0; i < DATA_W; i++) begin
                p[k] = p[k] ^ (d[i] & H_COLS[i][k]);
            end
        end
        return p;
    endfunction

    logic [PARITY_W-1:0] syndrome;
    logic [DATA_W-1:0]   flip_mask;
    logic                col_hit;
    logic                chk_hit;

    assign parity_out = encode(data_in);
    assign syndrome   = parity_in ^ parity_out;

    // one-hot mask of the data bit whose column equals the syndrome
    always_comb begin
        flip_mask = '0;
        for (int i = 0; i < DATA_W; i++) begin
            flip_mask[i] = (syndrome == H_COLS[i]);
        end
    end

    assign col_hit = |flip_mask;
    assign chk_hit = $onehot(syndrome); // a check bit alone went bad

    assign data_out = bypass ? data_in : (data_in ^ flip_mask);
    assign sbit_err = !bypass && (col_hit || chk_hit);

    // even-weight or unused syndromes
    assign dbit_err = !bypass && (syndrome != '0) && !col_hit && !chk_hit;

endmodule

// File: logic/secded_pkg.sv
package secded_pkg;

    // (62,55) SECDED code, stored as {check bits, data bits}
    localparam int DATA_W   = 55;
    localparam int PARITY_W = 7;
    localparam int CODE_W   = DATA_W + PARITY_W;

    typedef enum logic [1:0] {
        ERR_NONE          = 2'd0,
        ERR_CORRECTED     = 2'd1, // single data bit flipped back, or bad check bit
        ERR_UNCORRECTABLE = 2'd2  // double-bit error, data returned as stored
    } err_status_e;

endpackage

// File: test/ecc_mem_tb.sv
module ecc_mem_tb
    import secded_pkg::*;
    import mem_req_pkg::*;
();

    localparam int ADDR_W       = 6;
    localparam int CNT_W        = 16;
    localparam int CLK_HALF     = 10;
    localparam int DRIVE_DLY    = 2;
    localparam int RESET_CYCLES = 16;

    logic                clk;
    logic                arst_n;
    logic                bypass;
    logic                req_valid;
    logic                req_ready;
    op_e                 req_op;
    logic [ADDR_W-1:0]   req_addr;
    logic [DATA_W-1:0]   req_wdata;
    logic [PARITY_W-1:0] req_wparity;
    logic                resp_valid;
    logic                resp_ready;
    logic [DATA_W-1:0]   resp_data;
    err_status_e         resp_status;
    logic [CNT_W-1:0]    sbit_count;
    logic [CNT_W-1:0]    dbit_count;
    logic [ADDR_W-1:0]   last_err_addr;

    logic [1:0]          vec_op[$];
    logic [ADDR_W-1:0]   vec_addr[$];
    logic [DATA_W-1:0]   vec_data[$];
    logic [PARITY_W-1:0] vec_par[$];
    logic                vec_byp[$];
    logic [DATA_W-1:0]   vec_exp[$];
    logic [1:0]          vec_st[$];
    int                  n_vec;
    bit                  vec_loaded = 1'b0;
    logic [31:0]         rng;
    logic [CNT_W-1:0]    exp_sbit;
    logic [CNT_W-1:0]    exp_dbit;
    logic [ADDR_W-1:0]   exp_last;

    ecc_mem_top #(.ADDR_W(ADDR_W), .CNT_W(CNT_W)) DUT (
        .clk (clk), .arst_n (arst_n), .bypass (bypass),
        .req_valid (req_valid), .req_ready (req_ready), .req_op (req_op),
        .req_addr (req_addr), .req_wdata (req_wdata), .req_wparity (req_wparity),
        .resp_valid (resp_valid), .resp_ready (resp_ready),
        .resp_data (resp_data), .resp_status (resp_status),
        .sbit_count (sbit_count), .dbit_count (dbit_count),
        .last_err_addr (last_err_addr)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) fail_now($sformatf("ERROR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_status(input string name, input err_status_e got,
                                input err_status_e exp);
        if (got !== exp) fail_now($sformatf("ERROR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_count(input string name, input logic [CNT_W-1:0] got,
                               input logic [CNT_W-1:0] exp);
        if (got !== exp) fail_now($sformatf("ERROR %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        if (got !== exp) fail_now($sformatf("ERROR %s got %h expected %h", name, got, exp));
    endtask

    task automatic load_vectors();
        int fd;
        int n;
        string line;
        logic [63:0] f_op, f_addr, f_data, f_par, f_byp, f_exp, f_st;
        fd = $fopen("test/ecc_testdata.txt", "r");
        if (fd == 0) fail_now("could not open test/ecc_testdata.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%h %h %h %h %h %h %h", f_op, f_addr, f_data, f_par,
                        f_byp, f_exp, f_st);
            if (n == 7) begin
                vec_op.push_back(f_op[1:0]);
                vec_addr.push_back(f_addr[ADDR_W-1:0]);
                vec_data.push_back(f_data[DATA_W-1:0]);
                vec_par.push_back(f_par[PARITY_W-1:0]);
                vec_byp.push_back(f_byp[0]);
                vec_exp.push_back(f_exp[DATA_W-1:0]);
                vec_st.push_back(f_st[1:0]);
            end else if (n > 0) begin
                fail_now("malformed line in the test data file");
            end
        end
        $fclose(fd);
        n_vec = vec_op.size();
    endtask

    // present one command and hold it until the accept edge
    task automatic send_cmd(input int i);
        bit accepted;
        accepted = 1'b0;
        @(posedge clk);
        #DRIVE_DLY;
        req_valid   = 1'b1;
        req_op      = op_e'(vec_op[i]);
        req_addr    = vec_addr[i];
        req_wdata   = vec_data[i];
        req_wparity = vec_par[i];
        bypass      = vec_byp[i]; // stays put until the response is taken
        while (!accepted) begin
            @(negedge clk);
            accepted = req_ready;
            @(posedge clk);
            #DRIVE_DLY;
        end
        req_valid = 1'b0;
    endtask

    task automatic collect_resp(input int i);
        logic [DATA_W-1:0] held_data;
        err_status_e       held_status;
        bit                seen;
        bit                done;
        seen        = 1'b0;
        done        = 1'b0;
        held_data   = '0;
        held_status = ERR_NONE;
        rng         = xorshift32(rng);
        resp_ready  = rng[4];
        while (!done) begin
            @(negedge clk);
            if (resp_valid) begin
                if (req_ready) fail_now("request channel was ready during a pending response");
                if (seen) begin
                    // stalled response must not move
                    check_data("resp_data held", resp_data, held_data);
                    check_status("resp_status held", resp_status, held_status);
                end
                held_data   = resp_data;
                held_status = resp_status;
                seen        = 1'b1;
                if (resp_ready) begin
                    check_data("resp_data", resp_data, vec_exp[i]);
                    check_status("resp_status", resp_status, err_status_e'(vec_st[i]));
                    done = 1'b1;
                end
            end
            @(posedge clk);
            #DRIVE_DLY;
            rng        = xorshift32(rng);
            resp_ready = done ? 1'b0 : rng[4];
        end
    endtask

    task automatic run_vector(input int i);
        int gap;
        rng = xorshift32(rng);
        gap = int'(rng[1:0]); // 0 to 3 idle cycles
        repeat (gap) @(posedge clk);
        send_cmd(i);
        if (vec_op[i] == OP_READ) begin
            collect_resp(i);
            if (vec_st[i] == 2'd1) begin
                exp_sbit++;
                exp_last = vec_addr[i];
            end else if (vec_st[i] == 2'd2) begin
                exp_dbit++;
                exp_last = vec_addr[i];
            end
            check_count("sbit_count", sbit_count, exp_sbit);
            check_count("dbit_count", dbit_count, exp_dbit);
        end
    endtask

    initial begin
        longint limit;
        wait (vec_loaded);
        limit = longint'(n_vec + 10) * 20 * 20;
        #(limit);
        fail_now("timeout while waiting for the DUT, responses stopped arriving");
    end

    initial begin
        arst_n      = 1'b0;
        bypass      = 1'b0;
        req_valid   = 1'b0;
        req_op      = OP_READ;
        req_addr    = '0;
        req_wdata   = '0;
        req_wparity = '0;
        resp_ready  = 1'b0;
        rng         = 32'haa7e_1b1b;
        exp_sbit    = '0;
        exp_dbit    = '0;
        exp_last    = '0;
        load_vectors();
        if (n_vec == 0) fail_now("the test data file holds no commands");
        vec_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        arst_n = 1'b1;
        if (req_ready !== 1'b1 || resp_valid !== 1'b0) fail_now("handshakes not idle after reset");
        check_count("sbit_count", sbit_count, '0);
        check_count("dbit_count", dbit_count, '0);
        check_addr("last_err_addr", last_err_addr, '0);
        for (int i = 0; i < n_vec; i++) begin
            run_vector(i);
        end
        check_count("sbit_count", sbit_count, exp_sbit);
        check_count("dbit_count", dbit_count, exp_dbit);
        check_addr("last_err_addr", last_err_addr, exp_last);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: test/ecc_testdata.txt
# columns (hex): op addr wdata wparity bypass exp_data exp_status
# op 0 read, 1 write, 2 raw write; status 0 clean, 1 corrected, 2 uncorrectable
1 01 2A5F00C3D1E4B7 00 0 00000000000000 0
1 02 7FFFFFFFFFFFFF 00 0 00000000000000 0
1 03 13579BDF02468A 00 0 00000000000000 0
0 01 00000000000000 00 0 2A5F00C3D1E4B7 0
0 02 00000000000000 00 0 7FFFFFFFFFFFFF 0
0 03 00000000000000 00 0 13579BDF02468A 0
2 04 00000000000007 40 0 00000000000000 0
0 04 00000000000000 00 0 00000000000007 0
2 05 60000000000000 41 0 00000000000000 0
0 05 00000000000000 00 0 60000000000000 0
2 10 00000000000006 40 0 00000000000000 0
0 10 00000000000000 00 0 00000000000007 1
0 10 00000000000000 00 0 00000000000007 0
2 11 00010000000008 32 0 00000000000000 0
0 11 00000000000000 00 0 00010000100008 1
0 11 00000000000000 00 0 00010000100008 0
2 12 00000000000400 4E 0 00000000000000 0
0 12 00000000000000 00 0 00000000000400 1
0 12 00000000000000 00 0 00000000000400 0
2 13 20000000000000 41 0 00000000000000 0
0 13 00000000000000 00 0 60000000000000 1
0 13 00000000000000 00 0 60000000000000 0
2 14 00000000000000 40 0 00000000000000 0
0 14 00000000000000 00 0 00000000000000 1
0 14 00000000000000 00 0 00000000000000 0
2 20 00000000000004 40 0 00000000000000 0
0 20 00000000000000 00 0 00000000000004 2
0 20 00000000000000 00 0 00000000000004 2
2 21 00000000000000 03 0 00000000000000 0
0 21 00000000000000 00 0 00000000000000 2
2 22 00000000000401 5F 0 00000000000000 0
0 22 00000000000000 00 0 00000000000401 2
2 30 00000000000006 40 0 00000000000000 0
0 30 00000000000000 00 1 00000000000006 0
0 30 00000000000000 00 0 00000000000007 1
0 30 00000000000000 00 0 00000000000007 0
2 31 00000000000004 40 0 00000000000000 0
0 31 00000000000000 00 1 00000000000004 0
1 10 5A5A5A5A5A5A5A 00 0 00000000000000 0
0 10 00000000000000 00 0 5A5A5A5A5A5A5A 0
0 22 00000000000000 00 0 00000000000401 2
